/* src/cache_pkg.sv */
package cache_pkg;

  // Geometry
  localparam int word_w         = 32;
  localparam int words_per_line = 4;
  localparam int offset_w       = 2;   // Word offset inside a line
  localparam int byte_off_w     = 2;   // Byte offset inside a word
  localparam int sets           = 16;
  localparam int index_w        = 4;
  localparam int tag_w          = 24;
  localparam int ways           = 4;
  localparam int age_w          = 2;
  localparam int line_w         = word_w * words_per_line;

  // Address field positions, addr = {tag, index, word offset, byte offset}
  localparam int index_lsb = byte_off_w + offset_w;   // Bit 4
  localparam int tag_lsb   = index_lsb + index_w;     // Bit 8

  localparam logic [age_w-1:0] age_max = '1;  // Saturation point of the age counters

  typedef logic [word_w-1:0] word_t;
  typedef word_t [words_per_line-1:0] line_t;  // Word 0 in the low bits
  typedef logic [ways-1:0] way_vec_t;

  typedef struct packed {
    logic              valid;
    logic              dirty;
    logic [age_w-1:0]  age;    // 0 = most recently used
    logic [tag_w-1:0]  tag;
  } line_meta_t;

  typedef line_meta_t [ways-1:0] set_meta_t;
  typedef line_t [ways-1:0] set_data_t;

  typedef struct packed {
    logic [word_w-1:0] addr;
    word_t             wdata;
    logic              rw;     // 0 read, 1 write
  } cpu_req_t;

  typedef struct packed {
    logic              enable;  // Held until mem_ready
    logic              rw;      // 0 read, 1 write
    logic [word_w-1:0] addr;    // Line aligned
    line_t             wdata;
  } mem_req_t;

  typedef enum logic [2:0] {idle, lookup, writeback, refill, update} ctrl_state_t;

endpackage

/* src/cache_ways.sv */
`timescale 1ns/1ns

module cache_ways
  import cache_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rd_en,
  input  logic [index_w-1:0]         rd_index,
  input  logic                       wr_en,
  input  logic [index_w-1:0]         wr_index,
  input  way_vec_t                   wr_way,    // One hot
  input  line_t                      wr_line,
  input  line_meta_t                 wr_meta,
  input  logic [ways-1:0][age_w-1:0] new_ages,  // Ages for every way of the set
  output set_meta_t                  set_meta,
  output set_data_t                  set_data
);

  set_meta_t meta_q [sets];   // Valid, dirty, age, tag
  set_data_t data_q [sets];   // Line storage
  set_meta_t meta_wr;         // Updated metadata of the written set

  // Selected way takes the new metadata, all ways take the new age
  always_comb begin
    meta_wr = meta_q[wr_index];
    for (int w = 0; w < ways; w++) begin
      if (wr_way[w])
        meta_wr[w] = wr_meta;
      meta_wr[w].age = new_ages[w];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < sets; s++)
        meta_q[s] <= '0;          // Cold cache
    end else if (wr_en) begin
      meta_q[wr_index] <= meta_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int w = 0; w < ways; w++)
        if (wr_way[w]) data_q[wr_index][w] <= wr_line;
    end
  end

  // Set read, value held until the next rd_en
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)     set_meta <= '0;
    else if (rd_en) set_meta <= meta_q[rd_index];
  end

  always_ff @(posedge clk) begin
    if (rd_en) set_data <= data_q[rd_index];
  end

endmodule

/* src/hit_lru.sv */
`timescale 1ns/1ns

module hit_lru
  import cache_pkg::*;
(
  input  set_meta_t                  set_meta,
  input  logic [tag_w-1:0]           req_tag,
  output logic                       hit,
  output way_vec_t                   hit_way,
  output way_vec_t                   victim_way,
  output logic                       victim_dirty,  // Victim needs write-back
  output logic [ways-1:0][age_w-1:0] ages_after
);

  logic [$clog2(ways)-1:0] vict_idx;
  logic [age_w-1:0]        max_age;

  // Tag compare on every way
  always_comb begin
    for (int w = 0; w < ways; w++)
      hit_way[w] = set_meta[w].valid && (set_meta[w].tag == req_tag);
  end

  assign hit = |hit_way;

  // Victim choice
  always_comb begin
    vict_idx = '0;
    max_age  = set_meta[0].age;
    for (int w = 1; w < ways; w++) begin
      if (set_meta[w].age > max_age) begin   // Strict compare keeps the lowest way on ties
        max_age  = set_meta[w].age;
        vict_idx = w[$clog2(ways)-1:0];
      end
    end
    // An invalid way always wins, lowest first
    for (int w = ways - 1; w >= 0; w--)
      if (!set_meta[w].valid) vict_idx = w[$clog2(ways)-1:0];
    victim_way           = '0;
    victim_way[vict_idx] = 1'b1;
  end

  assign victim_dirty = set_meta[vict_idx].valid && set_meta[vict_idx].dirty;

  // Age update
  always_comb begin
    for (int w = 0; w < ways; w++) begin
      ages_after[w] = set_meta[w].age;          // Default keep
      if (hit) begin
        if (hit_way[w]) ages_after[w] = '0;     // Touched way becomes youngest
      end else if (victim_way[w]) begin
        ages_after[w] = '0;                     // Refilled way
      end else if (set_meta[w].valid && set_meta[w].age != age_max) begin
        ages_after[w] = set_meta[w].age + 1'b1; // Others grow older, saturating
      end
    end
  end

endmodule

/* src/line_merge.sv */
`timescale 1ns/1ns

module line_merge
  import cache_pkg::*;
(
  input  set_data_t  set_data,
  input  set_meta_t  set_meta,
  input  logic       hit,
  input  way_vec_t   hit_way,
  input  way_vec_t   victim_way,
  input  cpu_req_t   req,
  input  line_t      fill_line,   // Line from memory on a miss
  output line_t      new_line,
  output line_meta_t new_meta,
  output word_t      rdata_word
);

  way_vec_t            tgt_way;   // Way that gets written in update
  line_t               tgt_line;
  line_meta_t          tgt_meta;
  logic [offset_w-1:0] word_sel;

  assign tgt_way  = hit ? hit_way : victim_way;
  assign word_sel = req.addr[byte_off_w +: offset_w];

  always_comb begin
    tgt_line = '0;
    tgt_meta = '0;
    for (int w = 0; w < ways; w++) begin
      if (tgt_way[w]) begin
        tgt_line = set_data[w];
        tgt_meta = set_meta[w];
      end
    end
  end

  // Base line, then the CPU word on a write
  always_comb begin
    new_line = hit ? tgt_line : fill_line;
    if (req.rw) new_line[word_sel] = req.wdata;
  end

  always_comb begin
    new_meta.valid = 1'b1;
    new_meta.dirty = req.rw || (hit && tgt_meta.dirty);  // Read hit keeps, read miss clears
    new_meta.age   = '0;                                  // Overwritten by the age vector
    new_meta.tag   = req.addr[tag_lsb +: tag_w];
  end

  assign rdata_word = new_line[word_sel];

endmodule

/* src/cache_fsm.sv */
`timescale 1ns/1ns

module cache_fsm
  import cache_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  cpu_req_t                   cpu_req,
  input  logic                       cpu_req_enable,
  input  logic                       hit,
  input  way_vec_t                   hit_way,
  input  way_vec_t                   victim_way,
  input  logic                       victim_dirty,
  input  set_meta_t                  set_meta,
  input  set_data_t                  set_data,
  input  logic [ways-1:0][age_w-1:0] ages_after,
  input  line_t                      new_line,
  input  line_meta_t                 new_meta,
  input  word_t                      rdata_word,
  input  line_t                      mem_rdata,
  input  logic                       mem_ready,
  output cpu_req_t                   req_q,
  output line_t                      fill_line,
  output logic                       rd_en,
  output logic [index_w-1:0]         rd_index,
  output logic                       wr_en,
  output logic [index_w-1:0]         wr_index,
  output way_vec_t                   wr_way,
  output line_t                      wr_line,
  output line_meta_t                 wr_meta,
  output logic [ways-1:0][age_w-1:0] new_ages,
  output mem_req_t                   mem_req,
  output word_t                      cpu_rdata,
  output logic                       cpu_res_ready,
  output logic                       busy
);

  ctrl_state_t        state, state_nxt;
  line_meta_t         victim_meta;
  line_t              victim_line;
  logic [index_w-1:0] req_index;
  logic [tag_w-1:0]   req_tag;

  // Accept only in idle, the set read starts on the same edge
  assign rd_en    = (state == idle) && cpu_req_enable;
  assign rd_index = cpu_req.addr[index_lsb +: index_w];

  always_ff @(posedge clk) begin
    if (rd_en) req_q <= cpu_req;
  end

  assign req_index = req_q.addr[index_lsb +: index_w];
  assign req_tag   = req_q.addr[tag_lsb +: tag_w];

  // Refill data, captured in the completing cycle
  always_ff @(posedge clk) begin
    if (state == refill && mem_ready) fill_line <= mem_rdata;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= idle;
    else        state <= state_nxt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle:      if (cpu_req_enable) state_nxt = lookup;
      lookup: begin
        if (hit)               state_nxt = update;
        else if (victim_dirty) state_nxt = writeback;  // Dirty line goes out first
        else                   state_nxt = refill;
      end
      writeback: if (mem_ready) state_nxt = refill;
      refill:    if (mem_ready) state_nxt = update;
      update:    state_nxt = idle;
      default:   state_nxt = idle;
    endcase
  end

  // Victim way contents, stable because the set register is not reloaded
  always_comb begin
    victim_meta = '0;
    victim_line = '0;
    for (int w = 0; w < ways; w++) begin
      if (victim_way[w]) begin
        victim_meta = set_meta[w];
        victim_line = set_data[w];
      end
    end
  end

  // Memory request held stable while waiting for mem_ready
  always_comb begin
    mem_req = '0;
    case (state)
      writeback: begin
        mem_req.enable = 1'b1;
        mem_req.rw     = 1'b1;
        mem_req.addr   = {victim_meta.tag, req_index, {index_lsb{1'b0}}};  // Victim address
        mem_req.wdata  = victim_line;
      end
      refill: begin
        mem_req.enable = 1'b1;
        mem_req.addr   = {req_tag, req_index, {index_lsb{1'b0}}};
      end
      default: ;
    endcase
  end

  // Array write and response in update
  assign wr_en         = (state == update);
  assign wr_index      = req_index;
  assign wr_way        = hit ? hit_way : victim_way;
  assign wr_line       = new_line;
  assign wr_meta       = new_meta;
  assign new_ages      = ages_after;
  assign cpu_res_ready = (state == update);
  assign cpu_rdata     = rdata_word;   // Valid with cpu_res_ready
  assign busy          = (state != idle);

endmodule

/* src/cache_ctrl_top.sv */
`timescale 1ns/1ns

module cache_ctrl_top
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // CPU side
  input  cpu_req_t cpu_req,
  input  logic     cpu_req_enable,  // Taken only in idle
  output word_t    cpu_rdata,
  output logic     cpu_res_ready,   // One pulse per request
  output logic     busy,
  // Memory side
  output mem_req_t mem_req,
  input  line_t    mem_rdata,
  input  logic     mem_ready
);

  cpu_req_t                    req_q;
  line_t                       fill_line;
  logic                        rd_en, wr_en;
  logic [index_w-1:0]          rd_index, wr_index;
  way_vec_t                    wr_way;
  line_t                       wr_line, new_line;
  line_meta_t                  wr_meta, new_meta;
  logic [ways-1:0][age_w-1:0]  new_ages, ages_after;
  set_meta_t                   set_meta;   // Registered set read
  set_data_t                   set_data;
  logic                        hit, victim_dirty;
  way_vec_t                    hit_way, victim_way;
  word_t                       rdata_word;

  cache_ways u_ways (
    .clk, .rst_n, .rd_en, .rd_index, .wr_en, .wr_index, .wr_way, .wr_line,
    .wr_meta, .new_ages, .set_meta, .set_data
  );

  hit_lru u_hit_lru (
    .set_meta, .req_tag(req_q.addr[tag_lsb +: tag_w]), .hit, .hit_way,
    .victim_way, .victim_dirty, .ages_after
  );

  line_merge u_merge (
    .set_data, .set_meta, .hit, .hit_way, .victim_way, .req(req_q), .fill_line,
    .new_line, .new_meta, .rdata_word
  );

  cache_fsm u_fsm (
    .clk, .rst_n, .cpu_req, .cpu_req_enable, .hit, .hit_way, .victim_way,
    .victim_dirty, .set_meta, .set_data, .ages_after, .new_line, .new_meta,
    .rdata_word, .mem_rdata, .mem_ready, .req_q, .fill_line, .rd_en, .rd_index,
    .wr_en, .wr_index, .wr_way, .wr_line, .wr_meta, .new_ages, .mem_req,
    .cpu_rdata, .cpu_res_ready, .busy
  );

endmodule

/* sim/tb_mem_model.sv */
`timescale 1ns/1ns

module tb_mem_model
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  mem_req_t   mem_req,
  input  logic [1:0] mem_lat,    // Extra wait cycles, 0 to 3
  output line_t      mem_rdata,
  output logic       mem_ready
);

  word_t       store [1024];      // One 4 KiB region, word addressed
  bit          written [1024];    // Word holds data from a write-back
  logic        active;            // Transfer in progress
  logic [1:0]  wait_cnt;
  logic [31:0] line_base;

  assign line_base = {mem_req.addr[31:4], 4'h0};

  // Contents before any write follow the full word address
  function automatic word_t load_word(input logic [31:0] a);
    if (written[a[11:2]])
      return store[a[11:2]];
    return a ^ 32'hA5A5A5A5;
  endfunction

  // Ready 1 to 4 cycles after the request is seen
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active    <= 1'b0;
      wait_cnt  <= '0;
      mem_ready <= 1'b0;
      mem_rdata <= '0;
    end else begin
      mem_ready <= 1'b0;
      if (!active) begin
        if (mem_req.enable && !mem_ready) begin  // Old request still up in the ready cycle
          active   <= 1'b1;
          wait_cnt <= mem_lat;
        end
      end else if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end else begin
        active    <= 1'b0;
        mem_ready <= 1'b1;
        for (int w = 0; w < words_per_line; w++) begin
          if (mem_req.rw) begin
            store[line_base[11:2] + w]   <= mem_req.wdata[w];
            written[line_base[11:2] + w] <= 1'b1;
          end else begin
            mem_rdata[w] <= load_word(line_base + 4 * w);  // Valid with mem_ready
          end
        end
      end
    end
  end

endmodule

/* sim/tb_cache_ctrl.sv */
`timescale 1ns/1ns

module tb_cache_ctrl
  import cache_pkg::*;
();

  logic       clk, rst_n;
  cpu_req_t   cpu_req;
  logic       cpu_req_enable;
  word_t      cpu_rdata;
  logic       cpu_res_ready, busy;
  mem_req_t   mem_req;
  line_t      mem_rdata;
  logic       mem_ready;
  logic [1:0] mem_lat;

  int            errors, checks;
  int            rd_cnt, wr_cnt;    // Completed memory transfers
  logic [15:0]   lfsr;
  word_t         shadow [1024];     // Flat copy of memory as the CPU sees it
  bit            shadow_vld [1024];
  logic [word_w:0] exp_q [$];       // {is_read, expected word} per request
  logic [31:0]   wb_exp_q [$];      // Predicted write-back addresses
  line_t         last_wb_line;
  // LRU model with one entry per set and way
  bit            m_valid [sets][ways];
  bit            m_dirty [sets][ways];
  bit [age_w-1:0] m_age  [sets][ways];
  bit [tag_w-1:0] m_tag  [sets][ways];

  cache_ctrl_top dut (
    .clk, .rst_n, .cpu_req, .cpu_req_enable, .cpu_rdata, .cpu_res_ready, .busy,
    .mem_req, .mem_rdata, .mem_ready
  );

  tb_mem_model mem (.clk, .rst_n, .mem_req, .mem_lat, .mem_rdata, .mem_ready);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // All traffic stays in one 4 KiB region
  function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
    return {20'h4B1D3, tag[3:0], set[3:0], word[1:0], 2'b00};
  endfunction

  // Last written value, else the power-up pattern of the word address
  function automatic word_t ref_read(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:2], 2'b00};
    if (shadow_vld[a[11:2]])
      return shadow[a[11:2]];
    return a ^ 32'hA5A5A5A5;
  endfunction

  task automatic check_eq(input logic [line_w-1:0] got, input logic [line_w-1:0] exp,
                          input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  endtask

  // Victim and age rules that also queue the write-back of a dirty victim
  task automatic model_access(input logic [31:0] addr, input logic rw);
    logic [index_w-1:0] s;
    logic [tag_w-1:0]   t;
    int                 hw, v;
    bit [age_w-1:0]     oldest;
    s  = addr[7:4];
    t  = addr[31:8];
    hw = -1;
    for (int w = 0; w < ways; w++)
      if (m_valid[s][w] && m_tag[s][w] == t) hw = w;
    if (hw >= 0) begin
      m_age[s][hw] = '0;                 // Other ages untouched on a hit
      if (rw) m_dirty[s][hw] = 1'b1;
      return;
    end
    v = -1;
    for (int w = ways - 1; w >= 0; w--)
      if (!m_valid[s][w]) v = w;         // Lowest free way first
    if (v < 0) begin
      oldest = '0;
      for (int w = 0; w < ways; w++)
        if (m_age[s][w] > oldest) oldest = m_age[s][w];
      for (int w = ways - 1; w >= 0; w--)
        if (m_age[s][w] == oldest) v = w;
    end
    if (m_valid[s][v] && m_dirty[s][v])
      wb_exp_q.push_back({m_tag[s][v], s, 4'h0});
    for (int w = 0; w < ways; w++)
      if (w != v && m_valid[s][w] && m_age[s][w] != age_max) m_age[s][w]++;
    m_valid[s][v] = 1'b1;
    m_dirty[s][v] = rw;
    m_age[s][v]   = '0;
    m_tag[s][v]   = t;
  endtask

  // Runs one request and returns the cycles from the accepting edge to cpu_res_ready
  task automatic issue_request(input logic [31:0] addr, input logic rw, input word_t wdata,
                               output int lat);
    int cycles;
    @(posedge clk);
    mem_lat        <= rand_bits(2);
    cpu_req.addr   <= addr;
    cpu_req.wdata  <= wdata;
    cpu_req.rw     <= rw;
    cpu_req_enable <= 1'b1;
    @(posedge clk);                      // Accepting edge while the DUT is idle
    cpu_req_enable <= 1'b0;
    if (rw) begin
      shadow[addr[11:2]]     = wdata;
      shadow_vld[addr[11:2]] = 1'b1;
      exp_q.push_back({1'b0, wdata});
    end else begin
      exp_q.push_back({1'b1, ref_read(addr)});
    end
    model_access(addr, rw);
    cycles = 0;
    lat    = 0;
    while (lat == 0) begin
      @(negedge clk);
      cycles++;
      check_eq(busy, 1'b1, "busy during request");
      if (cpu_res_ready) begin
        lat = cycles;
      end else if (cycles >= 200) begin
        $display("Timed out after 200 cycles waiting for cpu_res_ready at %0t", $time);
        errors++;
        finish_run();
      end
    end
  endtask

  // Response checker
  always @(negedge clk) begin : compare_responses
    logic [word_w:0] e;
    if (rst_n && cpu_res_ready) begin
      if (exp_q.size() == 0) begin
        $display("Response at %0t arrived with no request outstanding", $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        if (e[word_w]) check_eq(cpu_rdata, e[word_w-1:0], "read data");
      end
    end
  end

  // Every write-back on the memory side must be predicted and carry current data
  always @(negedge clk) begin : watch_memory
    logic [31:0] a;
    if (rst_n && mem_req.enable && mem_ready) begin
      if (!mem_req.rw) begin
        rd_cnt++;
      end else begin
        wr_cnt++;
        a            = mem_req.addr;
        last_wb_line = mem_req.wdata;
        if (wb_exp_q.size() == 0) begin
          $display("Write-back to %h at %0t was not expected", a, $time);
          errors++;
        end else begin
          check_eq(a, wb_exp_q.pop_front(), "write-back address");
        end
        for (int w = 0; w < words_per_line; w++)
          check_eq(mem_req.wdata[w], ref_read(a + 4 * w), "write-back word");
      end
    end
  end

  initial begin : stimulus
    int          lat;
    int          sel, tg, wd;
    logic        rw_r;
    word_t       wdat;
    errors         = 0;
    checks         = 0;
    rd_cnt         = 0;
    wr_cnt         = 0;
    lfsr           = 16'd65160;
    rst_n          = 1'b0;
    cpu_req        = '0;
    cpu_req_enable = 1'b0;
    mem_lat        = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq(busy, 0, "busy after reset");
    check_eq(mem_req.enable, 0, "mem_req.enable after reset");
    check_eq(cpu_res_ready, 0, "cpu_res_ready after reset");

    // Cold read miss
    issue_request(make_addr(1, 2, 1), 1'b0, '0, lat);
    check_eq(rd_cnt, 1, "memory reads on cold miss");
    check_eq(wr_cnt, 0, "write-backs on cold miss");

    // Read hit on the same line
    issue_request(make_addr(1, 2, 3), 1'b0, '0, lat);
    check_eq(lat, 2, "read hit latency");
    check_eq(rd_cnt, 1, "memory reads on hit");

    // Write hit, then the whole line back
    issue_request(make_addr(1, 2, 2), 1'b1, 32'h5EED0001, lat);
    check_eq(lat, 2, "write hit latency");
    for (int w = 0; w < words_per_line; w++)
      issue_request(make_addr(1, 2, w), 1'b0, '0, lat);
    check_eq(rd_cnt, 1, "memory reads after write hit");

    // Write miss ages out after four more tags in set 5
    issue_request(make_addr(2, 5, 0), 1'b1, 32'h0DDBA11, lat);
    for (int t = 3; t < 7; t++)
      issue_request(make_addr(t, 5, 1), 1'b0, '0, lat);
    check_eq(wr_cnt, 1, "write-backs after set overflow");
    check_eq(last_wb_line[0], 32'h0DDBA11, "merged word in write-back line");

    // Random traffic over sets 3, 7, 11 and tags 8 to 15
    for (int n = 0; n < 200; n++) begin
      sel  = rand_bits(2) % 3;
      tg   = 8 + rand_bits(3);
      wd   = rand_bits(2);
      rw_r = rand_bits(1);
      wdat = rw_r ? rand_bits(32) : '0;
      issue_request(make_addr(tg, 3 + 4 * sel, wd), rw_r, wdat, lat);
    end

    repeat (2) @(posedge clk);
    check_eq(wb_exp_q.size(), 0, "predicted write-backs never seen");
    check_eq(busy, 0, "busy after last request");
    finish_run();
  end

endmodule

/* sources.f */
src/cache_pkg.sv
src/cache_ways.sv
src/hit_lru.sv
src/line_merge.sv
src/cache_fsm.sv
src/cache_ctrl_top.sv
sim/tb_mem_model.sv
sim/tb_cache_ctrl.sv

/* Bender.yml */
package:
  name: cache_ctrl

sources:
  - src/cache_pkg.sv
  - src/cache_ways.sv
  - src/hit_lru.sv
  - src/line_merge.sv
  - src/cache_fsm.sv
  - src/cache_ctrl_top.sv
  - target: simulation
    files:
      - sim/tb_mem_model.sv
      - sim/tb_cache_ctrl.sv
